//--- include/mac_rx_defines.svh
`ifndef MAC_RX_DEFINES_SVH
`define MAC_RX_DEFINES_SVH

// Receive FIFO geometry
`define MAC_FIFO_DEPTH 16
`define MAC_OCC_W 5

// Register offsets on the AXI4-Lite port
`define CSR_FRAMES0 8'h00
`define CSR_FRAMES1 8'h04
`define CSR_ERRORS 8'h08
`define CSR_STATUS 8'h0C
`define CSR_CLEAR 8'h10

// Frame and error counter width
`define CNT_W 16

`endif

//--- logic/mac_rx_csr.sv
`timescale 1ns/1ps
`include "mac_rx_defines.svh"

module mac_rx_csr (
   input  logic                      clk,
   input  logic                      rst,
   input  mac_rx_pkg::buf_wr_t       buf_wr_i,
   input  logic                      frame_port_i,
   input  logic [`MAC_OCC_W-1:0]     occ0_i,
   input  logic [`MAC_OCC_W-1:0]     occ1_i,
   input  mac_rx_pkg::axil_req_t     axil_req_i,
   output mac_rx_pkg::axil_rsp_t     axil_rsp_o
);

   localparam logic [1:0] RESP_OKAY = 2'b00;

   logic [`CNT_W-1:0]  frames0;
   logic [`CNT_W-1:0]  frames1;
   logic [`CNT_W-1:0]  errors;
   logic               frame_done;
   logic               wr_hs;
   logic               rd_hs;
   logic               clear;
   logic               b_valid;
   logic               r_valid;
   logic [31:0]        r_data;
   logic [31:0]        rd_mux;

   assign frame_done = buf_wr_i.write & buf_wr_i.done;

   // Address and data are taken together, one write at a time
   assign wr_hs = axil_req_i.aw_valid & axil_req_i.w_valid & ~b_valid;
   assign rd_hs = axil_req_i.ar_valid & ~r_valid;
   assign clear = wr_hs & (axil_req_i.aw_addr == `CSR_CLEAR);

   always_ff @(posedge clk) begin
      if (rst || clear) begin
         frames0 <= '0;
         frames1 <= '0;
         errors  <= '0;
      end else if (frame_done) begin
         if (frame_port_i) begin
            frames1 <= frames1 + 1'b1;
         end else begin
            frames0 <= frames0 + 1'b1;
         end
         if (buf_wr_i.error) begin
            errors <= errors + 1'b1;
         end
      end
   end

   always_comb begin
      case (axil_req_i.ar_addr)
         `CSR_FRAMES0: rd_mux = {{(32-`CNT_W){1'b0}}, frames0};
         `CSR_FRAMES1: rd_mux = {{(32-`CNT_W){1'b0}}, frames1};
         `CSR_ERRORS:  rd_mux = {{(32-`CNT_W){1'b0}}, errors};
         `CSR_STATUS:  rd_mux = {{(16-`MAC_OCC_W){1'b0}}, occ1_i,
                                 {(16-`MAC_OCC_W){1'b0}}, occ0_i};
         default:      rd_mux = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         b_valid <= 1'b0;
         r_valid <= 1'b0;
      end else begin
         if (wr_hs) begin
            b_valid <= 1'b1;
         end else if (axil_req_i.b_ready) begin
            b_valid <= 1'b0;
         end
         if (rd_hs) begin
            r_valid <= 1'b1;
         end else if (axil_req_i.r_ready) begin
            r_valid <= 1'b0;
         end
      end
   end

   // Read data is captured at the address handshake
   always_ff @(posedge clk) begin
      if (rd_hs) begin
         r_data <= rd_mux;
      end
   end

   assign axil_rsp_o.aw_ready = wr_hs;
   assign axil_rsp_o.w_ready  = wr_hs;
   assign axil_rsp_o.b_valid  = b_valid;
   assign axil_rsp_o.b_resp   = RESP_OKAY;
   assign axil_rsp_o.ar_ready = rd_hs;
   assign axil_rsp_o.r_valid  = r_valid;
   assign axil_rsp_o.r_data   = r_data;
   assign axil_rsp_o.r_resp   = RESP_OKAY;

   // Read response holds steady until the master takes it
   a_r_hold: assert property (@(posedge clk) disable iff (rst)
      r_valid && !axil_req_i.r_ready |=> r_valid && $stable(r_data));

endmodule

//--- logic/mac_rx_fifo_if.sv
`timescale 1ns/1ps
`include "mac_rx_defines.svh"

module mac_rx_fifo_if (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      mac_empty_i,
   output logic                      mac_rd_o,
   input  mac_rx_pkg::mac_word_t     mac_word_i,
   output mac_rx_pkg::buf_wr_t       wr_o,
   input  logic                      wr_ready_i,
   input  logic                      wr_full_i,
   output logic                      pkt_pending_o,
   output logic [`MAC_OCC_W-1:0]     fifo_occupied_o,
   output logic                      fifo_full_o,
   output logic                      fifo_empty_o
);

   import mac_rx_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_HAVE_FRAME,
      ST_XFER,
      ST_ERROR
   } rd_state_t;

   rd_state_t  state;
   mac_word_t  fifo_head;
   logic       fifo_wr;
   logic       fifo_rd;
   logic       fifo_full;
   logic       fifo_empty;
   logic       xfer_word;

   // Pop the MAC whenever there is room
   assign fifo_wr  = ~fifo_full & ~mac_empty_i;
   assign mac_rd_o = fifo_wr;

   short_fifo u_fifo (
      .clk        (clk),
      .rst        (rst),
      .wr_data_i  (mac_word_i),
      .write_i    (fifo_wr),
      .full_o     (fifo_full),
      .rd_data_o  (fifo_head),
      .read_i     (fifo_rd),
      .empty_o    (fifo_empty),
      .occupied_o (fifo_occupied_o)
   );

   assign fifo_full_o  = fifo_full;
   assign fifo_empty_o = fifo_empty;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: begin
               if (fifo_head.sop && !fifo_empty) begin
                  state <= ST_HAVE_FRAME;
               end
            end
            ST_HAVE_FRAME: begin
               if (wr_ready_i) begin
                  state <= ST_XFER;
               end
            end
            ST_XFER: begin
               // End of frame wins over a full buffer
               if (fifo_head.eop && !fifo_empty) begin
                  state <= ST_IDLE;
               end else if (wr_full_i) begin
                  state <= ST_HAVE_FRAME;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   assign xfer_word = ~fifo_empty & (state == ST_XFER);

   // Stray words ahead of a frame start are dropped in idle
   assign fifo_rd = xfer_word | (~fifo_empty & (state == ST_IDLE) & ~fifo_head.sop);

   assign wr_o.data  = fifo_head.data;
   assign wr_o.be    = fifo_head.be;
   assign wr_o.write = xfer_word;
   assign wr_o.done  = xfer_word & fifo_head.eop;
   assign wr_o.error = xfer_word & fifo_head.err;

   assign pkt_pending_o = (state == ST_HAVE_FRAME);

endmodule

//--- logic/mac_rx_pkg.sv
package mac_rx_pkg;

   // One word from the MAC receive interface
   typedef struct packed {
      logic        sop;
      logic        eop;
      logic        err;
      logic [1:0]  be;
      logic [31:0] data;
   } mac_word_t;

   // One write toward the packet buffer
   typedef struct packed {
      logic [31:0] data;
      logic [1:0]  be;
      logic        write;
      logic        done;
      logic        error;
   } buf_wr_t;

   // AXI4-Lite master to slave
   typedef struct packed {
      logic        aw_valid;
      logic [7:0]  aw_addr;
      logic        w_valid;
      logic [31:0] w_data;
      logic [3:0]  w_strb;
      logic        b_ready;
      logic        ar_valid;
      logic [7:0]  ar_addr;
      logic        r_ready;
   } axil_req_t;

   // AXI4-Lite slave to master
   typedef struct packed {
      logic        aw_ready;
      logic        w_ready;
      logic        b_valid;
      logic [1:0]  b_resp;
      logic        ar_ready;
      logic        r_valid;
      logic [31:0] r_data;
      logic [1:0]  r_resp;
   } axil_rsp_t;

endpackage

//--- logic/mac_rx_top.sv
`timescale 1ns/1ps
`include "mac_rx_defines.svh"

module mac_rx_top (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      mac0_empty_i,
   output logic                      mac0_rd_o,
   input  mac_rx_pkg::mac_word_t     mac0_word_i,
   input  logic                      mac1_empty_i,
   output logic                      mac1_rd_o,
   input  mac_rx_pkg::mac_word_t     mac1_word_i,
   output mac_rx_pkg::buf_wr_t       buf_wr_o,
   input  logic                      buf_ready_i,
   input  logic                      buf_full_i,
   input  mac_rx_pkg::axil_req_t     axil_req_i,
   output mac_rx_pkg::axil_rsp_t     axil_rsp_o
);

   import mac_rx_pkg::*;

   buf_wr_t                port0_wr;
   buf_wr_t                port1_wr;
   buf_wr_t                merged_wr;
   logic [1:0]             pend;
   logic [1:0]             port_ready;
   logic [1:0]             port_full;
   logic [`MAC_OCC_W-1:0]  occ0;
   logic [`MAC_OCC_W-1:0]  occ1;
   logic                   frame_port;

   mac_rx_fifo_if u_port0 (
      .clk             (clk),
      .rst             (rst),
      .mac_empty_i     (mac0_empty_i),
      .mac_rd_o        (mac0_rd_o),
      .mac_word_i      (mac0_word_i),
      .wr_o            (port0_wr),
      .wr_ready_i      (port_ready[0]),
      .wr_full_i       (port_full[0]),
      .pkt_pending_o   (pend[0]),
      .fifo_occupied_o (occ0),
      .fifo_full_o     (),
      .fifo_empty_o    ()
   );

   mac_rx_fifo_if u_port1 (
      .clk             (clk),
      .rst             (rst),
      .mac_empty_i     (mac1_empty_i),
      .mac_rd_o        (mac1_rd_o),
      .mac_word_i      (mac1_word_i),
      .wr_o            (port1_wr),
      .wr_ready_i      (port_ready[1]),
      .wr_full_i       (port_full[1]),
      .pkt_pending_o   (pend[1]),
      .fifo_occupied_o (occ1),
      .fifo_full_o     (),
      .fifo_empty_o    ()
   );

   rx_packet_merge u_merge (
      .clk          (clk),
      .rst          (rst),
      .pend_i       (pend),
      .port0_wr_i   (port0_wr),
      .port1_wr_i   (port1_wr),
      .port_ready_o (port_ready),
      .port_full_o  (port_full),
      .buf_wr_o     (merged_wr),
      .buf_ready_i  (buf_ready_i),
      .buf_full_i   (buf_full_i),
      .frame_port_o (frame_port)
   );

   // The status block watches the same merged stream that leaves the top
   mac_rx_csr u_csr (
      .clk          (clk),
      .rst          (rst),
      .buf_wr_i     (merged_wr),
      .frame_port_i (frame_port),
      .occ0_i       (occ0),
      .occ1_i       (occ1),
      .axil_req_i   (axil_req_i),
      .axil_rsp_o   (axil_rsp_o)
   );

   assign buf_wr_o = merged_wr;

endmodule

//--- logic/rx_packet_merge.sv
`timescale 1ns/1ps

module rx_packet_merge (
   input  logic                  clk,
   input  logic                  rst,
   input  logic [1:0]            pend_i,
   input  mac_rx_pkg::buf_wr_t   port0_wr_i,
   input  mac_rx_pkg::buf_wr_t   port1_wr_i,
   output logic [1:0]            port_ready_o,
   output logic [1:0]            port_full_o,
   output mac_rx_pkg::buf_wr_t   buf_wr_o,
   input  logic                  buf_ready_i,
   input  logic                  buf_full_i,
   output logic                  frame_port_o
);

   import mac_rx_pkg::*;

   logic     busy;
   logic     grant;
   logic     last_port;
   logic     next_port;
   logic     frame_end;
   buf_wr_t  sel_wr;
   logic [1:0] grant_mask;

   // Round robin only matters when both ports wait
   always_comb begin
      if (pend_i == 2'b11) begin
         next_port = ~last_port;
      end else begin
         next_port = pend_i[1];
      end
   end

   assign sel_wr    = grant ? port1_wr_i : port0_wr_i;
   assign frame_end = busy & sel_wr.write & sel_wr.done;

   always_ff @(posedge clk) begin
      if (rst) begin
         busy      <= 1'b0;
         grant     <= 1'b0;
         last_port <= 1'b1;
      end else if (!busy) begin
         if (pend_i != 2'b00) begin
            busy      <= 1'b1;
            grant     <= next_port;
            last_port <= next_port;
         end
      end else if (frame_end) begin
         // Whole frame sent, release for the next grant
         busy <= 1'b0;
      end
   end

   assign grant_mask = busy ? (2'b01 << grant) : 2'b00;

   // Buffer flow control reaches the granted port only
   assign port_ready_o = grant_mask & {2{buf_ready_i}};
   assign port_full_o  = grant_mask & {2{buf_full_i}};

   always_comb begin
      if (busy) begin
         buf_wr_o = sel_wr;
      end else begin
         buf_wr_o = '0;
      end
   end

   assign frame_port_o = grant;

   // A port may only write while it holds the grant
   a_port0_granted: assert property (@(posedge clk) disable iff (rst)
      port0_wr_i.write |-> busy && !grant);

   a_port1_granted: assert property (@(posedge clk) disable iff (rst)
      port1_wr_i.write |-> busy && grant);

endmodule

//--- logic/short_fifo.sv
`timescale 1ns/1ps
`include "mac_rx_defines.svh"

module short_fifo (
   input  logic                      clk,
   input  logic                      rst,
   input  mac_rx_pkg::mac_word_t     wr_data_i,
   input  logic                      write_i,
   output logic                      full_o,
   output mac_rx_pkg::mac_word_t     rd_data_o,
   input  logic                      read_i,
   output logic                      empty_o,
   output logic [`MAC_OCC_W-1:0]     occupied_o
);

   import mac_rx_pkg::*;

   localparam int PTR_W = $clog2(`MAC_FIFO_DEPTH);

   mac_word_t              mem [`MAC_FIFO_DEPTH];
   logic [PTR_W-1:0]       wr_ptr;
   logic [PTR_W-1:0]       rd_ptr;
   logic [`MAC_OCC_W-1:0]  count;

   // Storage has no reset, only the pointers do
   always_ff @(posedge clk) begin
      if (write_i) begin
         mem[wr_ptr] <= wr_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         // Depth is a power of two so the pointers wrap naturally
         if (write_i) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (read_i) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         count <= '0;
      end else begin
         case ({write_i, read_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign rd_data_o  = mem[rd_ptr];
   assign full_o     = (count == `MAC_OCC_W'(`MAC_FIFO_DEPTH));
   assign empty_o    = (count == '0);
   assign occupied_o = count;

   // Callers must respect the flags
   a_no_overrun: assert property (@(posedge clk) disable iff (rst)
      !(write_i && full_o) && !(read_i && empty_o));

endmodule

//--- tb.f
+incdir+include
logic/mac_rx_pkg.sv
logic/short_fifo.sv
logic/mac_rx_fifo_if.sv
logic/rx_packet_merge.sv
logic/mac_rx_csr.sv
logic/mac_rx_top.sv
verif/tb_clock.sv
verif/rx_checker.sv
verif/mac_rx_tb.sv

//--- verif/mac_rx_tb.sv
`timescale 1ns/1ps
`include "mac_rx_defines.svh"

module mac_rx_tb;

   import mac_rx_pkg::*;

   localparam string TRACE_FILE = "verif/mac_rx_trace.txt";

   logic       clk;
   logic       rst;
   logic       feed;
   logic       mac0_empty;
   logic       mac0_rd;
   mac_word_t  mac0_word;
   logic       mac1_empty;
   logic       mac1_rd;
   mac_word_t  mac1_word;
   buf_wr_t    buf_wr;
   logic       buf_ready;
   logic       buf_full;
   axil_req_t  axil_req;
   axil_rsp_t  axil_rsp;
   mac_word_t  port0_q [$];
   mac_word_t  port1_q [$];
   int         idx0;
   int         idx1;
   int         exp_frames0;
   int         exp_frames1;
   int         exp_errors;
   int         total_frames;
   int         frames_seen;
   int         cycle_limit;
   int         cycles;
   int         reads_issued;
   int         tb_errors;
   int         chk_errors;
   integer     seed;

   tb_clock u_clock (.clk_o(clk));

   mac_rx_top dut (
      .clk          (clk),
      .rst          (rst),
      .mac0_empty_i (mac0_empty),
      .mac0_rd_o    (mac0_rd),
      .mac0_word_i  (mac0_word),
      .mac1_empty_i (mac1_empty),
      .mac1_rd_o    (mac1_rd),
      .mac1_word_i  (mac1_word),
      .buf_wr_o     (buf_wr),
      .buf_ready_i  (buf_ready),
      .buf_full_i   (buf_full),
      .axil_req_i   (axil_req),
      .axil_rsp_o   (axil_rsp)
   );

   rx_checker chk (
      .clk           (clk),
      .rst           (rst),
      .buf_wr_i      (buf_wr),
      .frame_port_i  (dut.frame_port),
      .pend_i        (dut.u_merge.pend_i),
      .mac_empty_i   ({mac1_empty, mac0_empty}),
      .mac_rd_i      ({mac1_rd, mac0_rd}),
      .axil_req_i    (axil_req),
      .axil_rsp_i    (axil_rsp),
      .exp_frames0_i (exp_frames0),
      .exp_frames1_i (exp_frames1),
      .exp_errors_i  (exp_errors),
      .frames_seen_o (frames_seen)
   );

   // Lines are "w port sop eop err be data" or "c frames0 frames1 errors"
   task automatic load_trace();
      integer            fd;
      int                n;
      int                port;
      int                sop;
      int                eop;
      int                err;
      int                be;
      logic [31:0]       data;
      logic [63:0]       tag;
      logic [8*128-1:0]  rest;
      mac_word_t         w;
      fd = $fopen(TRACE_FILE, "r");
      if (fd == 0) begin
         $display("ERROR cannot open trace file %s", TRACE_FILE);
         tb_errors++;
         return;
      end
      while ($fscanf(fd, " %s", tag) == 1) begin
         if (tag == "#") begin
            n = $fgets(rest, fd);
         end else if (tag == "w") begin
            n = $fscanf(fd, " %d %d %d %d %h %h", port, sop, eop, err, be, data);
            w.sop  = sop[0];
            w.eop  = eop[0];
            w.err  = err[0];
            w.be   = be[1:0];
            w.data = data;
            if (port == 0) begin
               port0_q.push_back(w);
            end else begin
               port1_q.push_back(w);
            end
            chk.expect_word(port, w);
         end else if (tag == "c") begin
            n = $fscanf(fd, " %d %d %d", exp_frames0, exp_frames1, exp_errors);
         end else begin
            $display("ERROR unknown trace line tag %0s", tag);
            tb_errors++;
         end
      end
      $fclose(fd);
   endtask

   task automatic axil_read(input logic [7:0] addr);
      axil_req.ar_addr  <= addr;
      axil_req.ar_valid <= 1'b1;
      @(posedge clk);
      while (!axil_rsp.ar_ready) @(posedge clk);
      axil_req.ar_valid <= 1'b0;
      @(posedge clk);
      while (!axil_rsp.r_valid) @(posedge clk);
      reads_issued++;
   endtask

   task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
      axil_req.aw_addr  <= addr;
      axil_req.aw_valid <= 1'b1;
      axil_req.w_data   <= data;
      axil_req.w_strb   <= 4'hF;
      axil_req.w_valid  <= 1'b1;
      @(posedge clk);
      while (!axil_rsp.aw_ready) @(posedge clk);
      axil_req.aw_valid <= 1'b0;
      axil_req.w_valid  <= 1'b0;
      @(posedge clk);
      while (!axil_rsp.b_valid) @(posedge clk);
   endtask

   // MAC side advances one word each time the DUT pops
   always @(posedge clk) begin
      if (feed) begin
         if (mac0_rd) idx0 = idx0 + 1;
         if (mac1_rd) idx1 = idx1 + 1;
         mac0_empty <= (idx0 >= port0_q.size());
         mac0_word  <= (idx0 < port0_q.size()) ? port0_q[idx0] : '0;
         mac1_empty <= (idx1 >= port1_q.size());
         mac1_word  <= (idx1 < port1_q.size()) ? port1_q[idx1] : '0;
      end
   end

   // Random buffer back-pressure
   always @(posedge clk) begin : flow_ctrl
      logic [31:0] r;
      if (feed) begin
         r = $random(seed);
         buf_full  <= (r[3:0] == 4'd0);
         buf_ready <= (r[6:5] != 2'b00);
      end
   end

   initial begin
      seed = 32'h744b_ba43;
      rst = 1'b1;
      feed = 1'b0;
      mac0_empty = 1'b1;
      mac0_word = '0;
      mac1_empty = 1'b1;
      mac1_word = '0;
      buf_ready = 1'b0;
      buf_full = 1'b0;
      axil_req = '0;
      axil_req.b_ready = 1'b1;
      axil_req.r_ready = 1'b1;
      idx0 = 0;
      idx1 = 0;
      load_trace();
      total_frames = exp_frames0 + exp_frames1;
      cycle_limit = (port0_q.size() + port1_q.size()) * 20 + 500;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      feed <= 1'b1;
      while (frames_seen < total_frames) @(posedge clk);
      // Counters land one cycle after the last done write
      repeat (3) @(posedge clk);
      axil_read(`CSR_FRAMES0);
      axil_read(`CSR_FRAMES1);
      axil_read(`CSR_ERRORS);
      axil_read(`CSR_STATUS);
      axil_read(8'h14);
      axil_write(`CSR_CLEAR, 32'h1);
      axil_read(`CSR_FRAMES0);
      axil_read(`CSR_FRAMES1);
      axil_read(`CSR_ERRORS);
      repeat (2) @(posedge clk);
      chk.final_check(reads_issued, chk_errors);
      $display("Run finished with %0d errors, %0d of %0d frames, %0d register reads",
               chk_errors + tb_errors, frames_seen, total_frames, reads_issued);
      if (chk_errors + tb_errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

   initial begin
      cycles = 0;
      wait (cycle_limit > 0);
      while (cycles < cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("TIMEOUT after %0d cycles with %0d frames still missing",
               cycles, total_frames - frames_seen);
      $display("Testbench failed");
      $finish;
   end

endmodule

//--- verif/mac_rx_trace.txt
# w port sop eop err be data : one MAC word, data in hex
# c frames0 frames1 errors : expected counter values at the end
w 0 1 0 0 3 a0000001
w 0 0 0 0 3 a0000002
w 0 0 0 0 3 a0000003
w 0 0 1 0 1 a0000004
w 0 0 0 0 3 dead0000
w 0 1 0 0 3 a1000001
w 0 0 0 0 3 a1000002
w 0 0 1 1 2 a1000003
w 0 1 0 0 3 a2000001
w 0 0 1 0 0 a2000002
w 0 1 1 0 3 a3000001
w 0 1 0 0 3 a4000001
w 0 0 0 0 3 a4000002
w 0 0 1 0 3 a4000003
w 1 1 0 0 3 b0000001
w 1 0 0 0 3 b0000002
w 1 0 0 0 3 b0000003
w 1 0 0 0 3 b0000004
w 1 0 1 0 2 b0000005
w 1 1 0 0 3 b1000001
w 1 0 0 0 3 b1000002
w 1 0 1 1 1 b1000003
w 1 0 0 0 3 beef0001
w 1 0 1 0 3 beef0002
w 1 1 0 0 3 b2000001
w 1 0 0 0 3 b2000002
w 1 0 0 0 3 b2000003
w 1 0 1 0 3 b2000004
c 5 3 2

//--- verif/rx_checker.sv
`timescale 1ns/1ps
`include "mac_rx_defines.svh"

module rx_checker (
   input  logic                   clk,
   input  logic                   rst,
   input  mac_rx_pkg::buf_wr_t    buf_wr_i,
   input  logic                   frame_port_i,
   input  logic [1:0]             pend_i,
   input  logic [1:0]             mac_empty_i,
   input  logic [1:0]             mac_rd_i,
   input  mac_rx_pkg::axil_req_t  axil_req_i,
   input  mac_rx_pkg::axil_rsp_t  axil_rsp_i,
   input  int                     exp_frames0_i,
   input  int                     exp_frames1_i,
   input  int                     exp_errors_i,
   output int                     frames_seen_o
);

   import mac_rx_pkg::*;

   mac_word_t   exp_q0 [$];
   mac_word_t   exp_q1 [$];
   bit          trace_in_frame [2];
   bit          frame_open;
   bit          open_port;
   bit          due_port;
   bit          alt_due;
   bit          cleared;
   logic [7:0]  rd_addr;
   int          errors;
   int          reads_seen;

   initial begin
      frames_seen_o = 0;
   end

   // Only words between a frame start and its end reach the buffer
   task automatic expect_word(input int port, input mac_word_t w);
      if (w.sop) begin
         trace_in_frame[port] = 1'b1;
      end
      if (trace_in_frame[port]) begin
         if (port == 0) begin
            exp_q0.push_back(w);
         end else begin
            exp_q1.push_back(w);
         end
      end
      if (w.eop) begin
         trace_in_frame[port] = 1'b0;
      end
   endtask

   task automatic report_mismatch(input string sig, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("CHECK FAILED t=%0t %s got %h expected %h", $time, sig, got, exp);
      errors++;
   endtask

   task automatic report_problem(input string what);
      $display("ERROR t=%0t %s", $time, what);
      errors++;
   endtask

   task automatic final_check(input int reads_expected, output int total_errors);
      if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
         report_problem($sformatf("%0d port0 and %0d port1 words never reached the buffer",
                                  exp_q0.size(), exp_q1.size()));
      end
      if (reads_seen != reads_expected) begin
         report_problem($sformatf("saw %0d register reads, %0d were issued",
                                  reads_seen, reads_expected));
      end
      total_errors = errors;
   endtask

   always @(posedge clk) begin : buf_monitor
      mac_word_t exp;
      if (!rst && buf_wr_i.write) begin
         if (frame_open && frame_port_i != open_port) begin
            report_problem("write from the other port inside an open frame");
         end
         if (!frame_open) begin
            // A port that waited through the previous frame is served next
            if (alt_due && frame_port_i != due_port) begin
               report_mismatch("frame_port_o", frame_port_i, due_port);
            end
            alt_due = 1'b0;
         end
         if (frame_port_i ? (exp_q1.size() == 0) : (exp_q0.size() == 0)) begin
            report_problem($sformatf("write from port %0d with no word expected",
                                     frame_port_i));
         end else begin
            exp = frame_port_i ? exp_q1.pop_front() : exp_q0.pop_front();
            if (buf_wr_i.data !== exp.data)
               report_mismatch("buf_wr_o.data", buf_wr_i.data, exp.data);
            if (buf_wr_i.be !== exp.be)
               report_mismatch("buf_wr_o.be", buf_wr_i.be, exp.be);
            if (buf_wr_i.done !== exp.eop)
               report_mismatch("buf_wr_o.done", buf_wr_i.done, exp.eop);
            if (buf_wr_i.error !== exp.err)
               report_mismatch("buf_wr_o.error", buf_wr_i.error, exp.err);
         end
         frame_open = !buf_wr_i.done;
         open_port = frame_port_i;
         if (buf_wr_i.done) begin
            frames_seen_o <= frames_seen_o + 1;
         end
      end
      if (!rst && frame_open && pend_i[!open_port]) begin
         alt_due = 1'b1;
         due_port = !open_port;
      end
   end

   // The MAC side is popped only while it has a word
   always @(posedge clk) begin : mac_monitor
      if (!rst) begin
         for (int p = 0; p < 2; p++) begin
            if (mac_rd_i[p] && mac_empty_i[p]) begin
               report_problem($sformatf("port %0d popped the MAC while it was empty", p));
            end
         end
      end
   end

   always @(posedge clk) begin : axil_monitor
      logic [31:0] exp_val;
      if (!rst) begin
         if (axil_req_i.aw_valid && axil_req_i.w_valid && axil_rsp_i.aw_ready &&
             axil_req_i.aw_addr == `CSR_CLEAR) begin
            cleared = 1'b1;
         end
         if (axil_rsp_i.b_valid && axil_req_i.b_ready && axil_rsp_i.b_resp !== 2'b00) begin
            report_mismatch("axil b_resp", axil_rsp_i.b_resp, 2'b00);
         end
         if (axil_req_i.ar_valid && axil_rsp_i.ar_ready) begin
            rd_addr = axil_req_i.ar_addr;
         end
         if (axil_rsp_i.r_valid && axil_req_i.r_ready) begin
            case (rd_addr)
               `CSR_FRAMES0: exp_val = cleared ? 32'd0 : exp_frames0_i;
               `CSR_FRAMES1: exp_val = cleared ? 32'd0 : exp_frames1_i;
               `CSR_ERRORS:  exp_val = cleared ? 32'd0 : exp_errors_i;
               // Both FIFOs are drained by the time status is read
               default:      exp_val = 32'd0;
            endcase
            if (axil_rsp_i.r_data !== exp_val)
               report_mismatch($sformatf("axil r_data @%h", rd_addr),
                               axil_rsp_i.r_data, exp_val);
            if (axil_rsp_i.r_resp !== 2'b00)
               report_mismatch("axil r_resp", axil_rsp_i.r_resp, 2'b00);
            reads_seen++;
         end
      end
   end

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
   parameter realtime HALF_PERIOD = 5ns
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
   end

   always #(HALF_PERIOD) clk_o = ~clk_o;

endmodule
